//--- compile.f
+incdir+hdl
hdl/emifBusPkg.sv
hdl/mmioRegPkg.sv
hdl/emifSlave.sv
hdl/mmioRegFile.sv
hdl/mmioReadback.sv
hdl/mmioClient.sv
sim/tbMmioClient.sv

//--- Bender.yml
package:
  name: mmio_client

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/emifBusPkg.sv
      - hdl/mmioRegPkg.sv
      - hdl/emifSlave.sv
      - hdl/mmioRegFile.sv
      - hdl/mmioReadback.sv
      - hdl/mmioClient.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tbMmioClient.sv

//--- sim/tbMmioClient.sv
/*
 * Self-checking testbench of the MMIO client. Builds a table of bus cycles
 * with expected read bytes and control snapshots, then applies it in a loop.
 */
`timescale 1ns/1ps
`include "mmio_params.svh"

module tbMmioClient
  import emifBusPkg::*;
  import mmioRegPkg::*;
();

  // -------------------------------------------------------------------------
  // DUT signals
  // -------------------------------------------------------------------------
  logic                        shlClk;
  logic                        reset;
  logic                        emifCsN;
  logic                        emifWeN;
  logic [`MMIO_BUS_ADDR_W-1:0] emifAddr;
  logic [`MMIO_DATA_W-1:0]     emifDataIn;
  logic [`MMIO_DATA_W-1:0]     emifDataOut;
  shellStatus                  status;
  eth0Ctrl                     eth0;
  ntsCfg                       nts;
  roleCtrl                     role;

  // One table row, controls are checked only when chkCtrl is set
  typedef struct
  {
    string                       name;
    emifOp                       op;       // opIdle marks a control checkpoint
    logic [`MMIO_BUS_ADDR_W-1:0] addr;     // Raw bus address, bit 7 included
    logic [`MMIO_DATA_W-1:0]     wdata;
    logic [`MMIO_DATA_W-1:0]     expRd;
    logic                        chkCtrl;
    eth0Ctrl                     expEth0;
    ntsCfg                       expNts;
    roleCtrl                     expRole;
    shellStatus                  stat;     // Status driven during the row
  } tableEntry;

  tableEntry  steps[$];
  eth0Ctrl    expEth0;                     // Expected controls while building
  ntsCfg      expNts;
  roleCtrl    expRole;
  shellStatus curStatus;
  integer     seed = 66163;
  logic [7:0] rnd[8];
  int         passCount = 0;
  int         failCount = 0;
  int         cycles;
  int         timeoutLimit = 0;

  mmioClient dut (
    .shlClk      (shlClk),
    .reset       (reset),
    .emifCsN     (emifCsN),
    .emifWeN     (emifWeN),
    .emifAddr    (emifAddr),
    .emifDataIn  (emifDataIn),
    .emifDataOut (emifDataOut),
    .status      (status),
    .eth0        (eth0),
    .nts         (nts),
    .role        (role)
  );

  initial
  begin
    shlClk = 1'b0;
    forever #10 shlClk = ~shlClk;          // 20 ns period
  end

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic checkByte(input string name,
                           input logic [`MMIO_DATA_W-1:0] exp,
                           input logic [`MMIO_DATA_W-1:0] act);
    if (act !== exp)
    begin
      failCount++;
      $display("Fail %s: expected %02h, actual %02h", name, exp, act);
    end
    else
    begin
      passCount++;
      $display("Pass %s: %02h", name, act);
    end
  endtask

  task automatic checkEth0(input string name, input eth0Ctrl exp, input eth0Ctrl act);
    if (act !== exp)
    begin
      failCount++;
      $display("Fail %s: expected %05h, actual %05h", name, exp, act);
    end
    else
    begin
      passCount++;
      $display("Pass %s: %05h", name, act);
    end
  endtask

  task automatic checkNts(input string name, input ntsCfg exp, input ntsCfg act);
    if (act !== exp)
    begin
      failCount++;
      $display("Fail %s: expected %036h, actual %036h", name, exp, act);
    end
    else
    begin
      passCount++;
      $display("Pass %s: %036h", name, act);
    end
  endtask

  task automatic checkRole(input string name, input roleCtrl exp, input roleCtrl act);
    if (act !== exp)
    begin
      failCount++;
      $display("Fail %s: expected %015h, actual %015h", name, exp, act);
    end
    else
    begin
      passCount++;
      $display("Pass %s: %015h", name, act);
    end
  endtask

  // -------------------------------------------------------------------------
  // Table building
  // -------------------------------------------------------------------------
  task automatic addStep(input string name, input emifOp op, input logic [7:0] addr,
                         input logic [7:0] wdata, input logic [7:0] expRd,
                         input logic chkCtrl);
    tableEntry e;
    e.name    = name;
    e.op      = op;
    e.addr    = addr;
    e.wdata   = wdata;
    e.expRd   = expRd;
    e.chkCtrl = chkCtrl;
    e.expEth0 = expEth0;                   // Snapshot of current expectation
    e.expNts  = expNts;
    e.expRole = expRole;
    e.stat    = curStatus;
    steps.push_back(e);
  endtask

  task automatic addWrite(input string name, input logic [7:0] addr, input logic [7:0] data);
    addStep(name, opWrite, addr, data, 8'h00, 1'b0);
  endtask

  task automatic addRead(input string name, input logic [7:0] addr, input logic [7:0] exp);
    addStep(name, opRead, addr, 8'h00, exp, 1'b0);
  endtask

  task automatic addWriteRead(input string name, input logic [7:0] addr, input logic [7:0] data);
    addWrite(name, addr, data);
    addRead(name, addr, data);             // Written byte comes back
  endtask

  task automatic addCheckpoint(input string name);
    addStep(name, opIdle, 8'h00, 8'h00, 8'h00, 1'b1);
  endtask

  // Drive on falling edge, result is stable two rising edges later
  task automatic applyStep(input tableEntry e);
    @(negedge shlClk);
    emifCsN    = (e.op == opIdle);
    emifWeN    = (e.op != opWrite);
    emifAddr   = e.addr;
    emifDataIn = e.wdata;
    status     = e.stat;
    @(negedge shlClk);
    emifCsN = 1'b1;
    emifWeN = 1'b1;
    @(negedge shlClk);
    if (e.op == opRead)
      checkByte(e.name, e.expRd, emifDataOut);
    if (e.chkCtrl)
    begin
      checkEth0({e.name, " eth0"}, e.expEth0, eth0);
      checkNts({e.name, " nts"}, e.expNts, nts);
      checkRole({e.name, " role"}, e.expRole, role);
    end
  endtask

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------
  initial
  begin
    reset      = 1'b1;
    emifCsN    = 1'b1;
    emifWeN    = 1'b1;
    emifAddr   = '0;
    emifDataIn = '0;
    status     = '0;
    curStatus  = '0;

    // Reset defaults, swing 4 and cursors 5
    expEth0 = '{rxEqualizerMode: 1'b1, txDriverSwing: 4'd4, txPreCursor: 5'd5,
                txPostCursor: 5'd5, default: '0};
    expNts  = '{macAddress: 48'h0, ipAddress: 32'h13C80C0A, subNetMask: 32'h0000FFFF,
                gatewayAddr: 32'h01000C0A};
    expRole = '0;
    addCheckpoint("reset controls");
    addRead("emif id", CFG_EMIF_ID, 8'h3C);
    addRead("emif ver", CFG_EMIF_VER, 8'h01);
    addRead("emif rev", CFG_EMIF_REV, 8'h00);
    addRead("top id", CFG_TOP_ID, 8'h81);
    addRead("scratch0 default", DIAG_SCRATCH0, 8'hDE);
    addRead("scratch1 default", DIAG_SCRATCH1, 8'hAD);
    addRead("scratch2 default", DIAG_SCRATCH2, 8'hBE);
    addRead("scratch3 default", DIAG_SCRATCH3, 8'hEF);

    // Writable registers
    addWriteRead("eth0 byte0", PHY_ETH0_0, 8'h70);   // Rx eq off, swing 7
    addWriteRead("eth0 byte1", PHY_ETH0_1, 8'h1F);
    addWriteRead("eth0 byte2", PHY_ETH0_2, 8'hE3);   // Upper bits not in field
    addWriteRead("mac0", LY2_MAC0, 8'h11);
    addWriteRead("mac1", LY2_MAC1, 8'h22);
    addWriteRead("mac2", LY2_MAC2, 8'h33);
    addWriteRead("mac3", LY2_MAC3, 8'h44);
    addWriteRead("mac4", LY2_MAC4, 8'h55);
    addWriteRead("mac5", LY2_MAC5, 8'h66);
    addWriteRead("ip0", LY3_IP0, 8'hC0);
    addWriteRead("ip1", LY3_IP1, 8'hA8);
    addWriteRead("ip2", LY3_IP2, 8'h01);
    addWriteRead("ip3", LY3_IP3, 8'h07);
    addWriteRead("diag ctrl1", DIAG_CTRL_1, 8'hC5);
    addWriteRead("diag ctrl2", DIAG_CTRL_2, 8'hB6);
    addWriteRead("role wr0", APP_WRROL0, 8'h34);
    addWriteRead("role wr1", APP_WRROL1, 8'h12);
    addWriteRead("fmc wr0", APP_WRFMC0, 8'h78);
    addWriteRead("fmc wr1", APP_WRFMC1, 8'h56);
    addWriteRead("fmc wr2", APP_WRFMC2, 8'h34);
    addWriteRead("fmc wr3", APP_WRFMC3, 8'h12);
    expEth0 = '{rxEqualizerMode: 1'b0, txDriverSwing: 4'h7, txPreCursor: 5'h1F,
                txPostCursor: 5'h03, pcsLoopbackEn: 1'b1, macLoopbackEn: 1'b0,
                macAddrSwapEn: 1'b1};                // Ctrl1 0xC5
    expNts.macAddress = 48'h665544332211;
    expNts.ipAddress  = 32'h0701A8C0;
    expRole = '{mc1MemTestCtrl: 2'b11, udpEchoCtrl: 2'b10, udpPostDgmEn: 1'b1,
                udpCaptDgmEn: 1'b0, tcpEchoCtrl: 2'b11, tcpPostSegEn: 1'b0,
                tcpCaptSegEn: 1'b1, roleWrReg: 16'h1234, fmcWrReg: 32'h12345678};
    addCheckpoint("controls after writes");

    // Live status, day 21 month 9 year 24
    curStatus = '{mc0CalDone: 1'b1, mc1CalDone: 1'b0, ethCoreReady: 1'b1, qpllLock: 1'b1,
                  camReady: 1'b0, memTestStat: 2'b10, roleRdReg: 16'hBEEF,
                  fmcRdReg: 32'hCAFE0123, timestamp: {5'd21, 4'd9, 6'd24, 17'h0ABC}};
    addRead("phy stat", PHY_STAT, 8'h0D);
    addRead("top year", CFG_TOP_YEAR, 8'h18);
    addRead("top month", CFG_TOP_MONTH, 8'h09);
    addRead("top day", CFG_TOP_DAY, 8'h15);
    addRead("role rd0", APP_RDROL0, 8'hEF);
    addRead("role rd1", APP_RDROL1, 8'hBE);
    addRead("fmc rd0", APP_RDFMC0, 8'h23);
    addRead("fmc rd1", APP_RDFMC1, 8'h01);
    addRead("fmc rd2", APP_RDFMC2, 8'hFE);
    addRead("fmc rd3", APP_RDFMC3, 8'hCA);
    addRead("diag stat1", DIAG_STAT_1, 8'h80);

    // Read-only, unassigned and upper half
    addWrite("emif id protect", CFG_EMIF_ID, 8'h55);
    addRead("emif id protect", CFG_EMIF_ID, 8'h3C);
    addWrite("phy stat protect", PHY_STAT, 8'hFF);
    addRead("phy stat protect", PHY_STAT, 8'h0D);
    addWrite("fmc rd0 protect", APP_RDFMC0, 8'h99);
    addRead("fmc rd0 protect", APP_RDFMC0, 8'h23);
    // Upper read follows a nonzero read so the bus must drop to zero
    addWrite("upper 0x90", 8'h90, 8'h5A);
    addRead("upper 0x90", 8'h90, 8'h00);
    addWrite("unassigned 0x50", 8'h50, 8'hA5);
    addRead("unassigned 0x50", 8'h50, 8'h00);
    addCheckpoint("controls after protected writes");

    // Random scratch and gateway bytes
    for (int i = 0; i < 8; i++)
      rnd[i] = $random(seed);
    addWriteRead("scratch0 random", DIAG_SCRATCH0, rnd[0]);
    addWriteRead("scratch1 random", DIAG_SCRATCH1, rnd[1]);
    addWriteRead("scratch2 random", DIAG_SCRATCH2, rnd[2]);
    addWriteRead("scratch3 random", DIAG_SCRATCH3, rnd[3]);
    addWriteRead("gateway0 random", LY3_GTW0, rnd[4]);
    addWriteRead("gateway1 random", LY3_GTW1, rnd[5]);
    addWriteRead("gateway2 random", LY3_GTW2, rnd[6]);
    addWriteRead("gateway3 random", LY3_GTW3, rnd[7]);
    expNts.gatewayAddr = {rnd[7], rnd[6], rnd[5], rnd[4]};   // Lower address low byte
    addCheckpoint("controls after random");

    timeoutLimit = 4 * (steps.size() + 20);

    repeat (2) @(posedge shlClk);
    @(negedge shlClk);
    reset = 1'b0;

    foreach (steps[i])
      applyStep(steps[i]);

    $display("Checks passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // -------------------------------------------------------------------------
  // Timeout
  // -------------------------------------------------------------------------
  initial
  begin
    cycles = 0;
    wait (timeoutLimit != 0);
    while (cycles < timeoutLimit)
    begin
      @(posedge shlClk);
      cycles++;
    end
    $display("Simulation timed out after %0d cycles before the table finished", cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- hdl/mmioClient.sv
/*
 * MMIO client top. Lets the PSoC control and monitor the shell over an
 * 8-bit EMIF bus synchronous to shlClk; read data follows two cycles later.
 */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioClient
  import emifBusPkg::*;
  import mmioRegPkg::*;
(
  input  logic                        shlClk,
  input  logic                        reset,
  // PSoC EMIF bus
  input  logic                        emifCsN,
  input  logic                        emifWeN,
  input  logic [`MMIO_BUS_ADDR_W-1:0] emifAddr,
  input  logic [`MMIO_DATA_W-1:0]     emifDataIn,
  output logic [`MMIO_DATA_W-1:0]     emifDataOut,
  // Shell side
  input  shellStatus                  status,
  output eth0Ctrl                     eth0,
  output ntsCfg                       nts,
  output roleCtrl                     role
);

  // -----------------------------------------------------------------------
  // Internal nets
  // -----------------------------------------------------------------------
  emifReq                                       req;     // Registered bus cycle
  logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] store;   // Writable byte image
  logic [`MMIO_DATA_W-1:0]                      rdByte;  // Selected read value

  emifSlave slave (
    .shlClk      (shlClk),
    .reset       (reset),
    .emifCsN     (emifCsN),
    .emifWeN     (emifWeN),
    .emifAddr    (emifAddr),
    .emifDataIn  (emifDataIn),
    .rdByte      (rdByte),
    .req         (req),
    .emifDataOut (emifDataOut)
  );

  mmioRegFile regFile (
    .shlClk (shlClk),
    .reset  (reset),
    .req    (req),
    .store  (store),
    .eth0   (eth0),
    .nts    (nts),
    .role   (role)
  );

  mmioReadback readback (
    .req    (req),
    .store  (store),
    .status (status),
    .rdByte (rdByte)
  );

endmodule

//--- hdl/mmioReadback.sv
/*
 * Read mux of the MMIO map. Picks the byte of the requested address from
 * ID constants, live shell status or the stored register image.
 */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioReadback
  import emifBusPkg::*;
  import mmioRegPkg::*;
(
  input  emifReq     req,
  input  logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] store,
  input  shellStatus status,
  output logic [`MMIO_DATA_W-1:0] rdByte
);

  // -----------------------------------------------------------------------
  // Status bytes
  // -----------------------------------------------------------------------
  logic [`MMIO_DATA_W-1:0] phyStat;
  logic [`MMIO_DATA_W-1:0] diagStat1;
  logic [`MMIO_DATA_W-1:0] topYear;
  logic [`MMIO_DATA_W-1:0] topMonth;
  logic [`MMIO_DATA_W-1:0] topDay;

  assign phyStat   = {3'b000,
                      status.camReady,
                      status.qpllLock,
                      status.ethCoreReady,
                      status.mc1CalDone,
                      status.mc0CalDone};         // Bit 0 is MC0
  assign diagStat1 = {status.memTestStat, 6'b000000};
  assign topYear   = {2'b00, status.timestamp[22:17]};   // Years since 2000
  assign topMonth  = {4'b0000, status.timestamp[26:23]};
  assign topDay    = {3'b000, status.timestamp[31:27]};

  // -----------------------------------------------------------------------
  // Address select
  // -----------------------------------------------------------------------
  always_comb
  begin
    case (req.addr)
      CFG_EMIF_ID:   rdByte = `MMIO_EMIF_ID;
      CFG_EMIF_VER:  rdByte = `MMIO_EMIF_VER;
      CFG_EMIF_REV:  rdByte = `MMIO_EMIF_REV;
      CFG_TOP_ID:    rdByte = `MMIO_TOP_ID;
      CFG_TOP_YEAR:  rdByte = topYear;
      CFG_TOP_MONTH: rdByte = topMonth;
      CFG_TOP_DAY:   rdByte = topDay;
      PHY_STAT:      rdByte = phyStat;
      // Status placeholders, nothing reported yet
      LY2_STAT,
      LY3_STAT0,
      LY3_STAT1:     rdByte = '0;
      APP_RDROL0:    rdByte = status.roleRdReg[7:0];
      APP_RDROL1:    rdByte = status.roleRdReg[15:8];
      APP_RDFMC0:    rdByte = status.fmcRdReg[7:0];
      APP_RDFMC1:    rdByte = status.fmcRdReg[15:8];
      APP_RDFMC2:    rdByte = status.fmcRdReg[23:16];
      APP_RDFMC3:    rdByte = status.fmcRdReg[31:24];
      DIAG_STAT_1:   rdByte = diagStat1;
      // Writable bytes, unassigned ones hold zero
      default:       rdByte = store[req.addr];
    endcase
  end

endmodule

//--- hdl/mmioRegFile.sv
/*
 * Writable register storage of the MMIO map. Loads the reset defaults,
 * applies bus writes to writable bytes only and unpacks the bytes into
 * the ETH0, network and role control groups.
 */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioRegFile
  import emifBusPkg::*;
  import mmioRegPkg::*;
(
  input  logic    shlClk,
  input  logic    reset,
  input  emifReq  req,
  output logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] store,  // Byte image
  output eth0Ctrl eth0,
  output ntsCfg   nts,
  output roleCtrl role
);

  // -----------------------------------------------------------------------
  // Write map and reset image
  // -----------------------------------------------------------------------
  function automatic logic isWritable(input logic [`MMIO_ADDR_W-1:0] a);
    case (a)
      PHY_ETH0_0, PHY_ETH0_1, PHY_ETH0_2,
      LY2_CTRL, LY2_MAC0, LY2_MAC1, LY2_MAC2, LY2_MAC3, LY2_MAC4, LY2_MAC5,
      LY3_CTRL0, LY3_CTRL1,
      LY3_IP0, LY3_IP1, LY3_IP2, LY3_IP3,
      LY3_SNM0, LY3_SNM1, LY3_SNM2, LY3_SNM3,
      LY3_GTW0, LY3_GTW1, LY3_GTW2, LY3_GTW3,
      APP_WRROL0, APP_WRROL1,
      APP_WRFMC0, APP_WRFMC1, APP_WRFMC2, APP_WRFMC3,
      DIAG_SCRATCH0, DIAG_SCRATCH1, DIAG_SCRATCH2, DIAG_SCRATCH3,
      DIAG_CTRL_1, DIAG_CTRL_2:
        isWritable = 1'b1;
      default:
        isWritable = 1'b0;   // RO and unassigned
    endcase
  endfunction

  function automatic logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] defaultImage();
    logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] img;
    img                = '0;   // Everything not listed resets to zero
    img[PHY_ETH0_0]    = `MMIO_DEF_PHY_ETH0_0;
    img[PHY_ETH0_1]    = `MMIO_DEF_PHY_ETH0_1;
    img[PHY_ETH0_2]    = `MMIO_DEF_PHY_ETH0_2;
    img[LY3_IP0]       = `MMIO_DEF_IP0;
    img[LY3_IP1]       = `MMIO_DEF_IP1;
    img[LY3_IP2]       = `MMIO_DEF_IP2;
    img[LY3_IP3]       = `MMIO_DEF_IP3;
    img[LY3_SNM0]      = `MMIO_DEF_SNM0;
    img[LY3_SNM1]      = `MMIO_DEF_SNM1;
    img[LY3_SNM2]      = `MMIO_DEF_SNM2;
    img[LY3_SNM3]      = `MMIO_DEF_SNM3;
    img[LY3_GTW0]      = `MMIO_DEF_GTW0;
    img[LY3_GTW1]      = `MMIO_DEF_GTW1;
    img[LY3_GTW2]      = `MMIO_DEF_GTW2;
    img[LY3_GTW3]      = `MMIO_DEF_GTW3;
    img[DIAG_SCRATCH0] = `MMIO_DEF_SCR0;
    img[DIAG_SCRATCH1] = `MMIO_DEF_SCR1;
    img[DIAG_SCRATCH2] = `MMIO_DEF_SCR2;
    img[DIAG_SCRATCH3] = `MMIO_DEF_SCR3;
    return img;
  endfunction

  localparam logic [`MMIO_REG_COUNT-1:0][`MMIO_DATA_W-1:0] DEF_IMAGE = defaultImage();

  // Byte storage, non-writable bytes stay at their zero reset value
  always_ff @(posedge shlClk)
  begin
    if (reset)
      store <= DEF_IMAGE;
    else if (req.op == opWrite && isWritable(req.addr))
      store[req.addr] <= req.data;
  end

  // -----------------------------------------------------------------------
  // Unpack into shell controls
  // -----------------------------------------------------------------------
  always_comb
  begin
    eth0.rxEqualizerMode = store[PHY_ETH0_0][0];
    eth0.txDriverSwing   = store[PHY_ETH0_0][7:4];
    eth0.txPreCursor     = store[PHY_ETH0_1][4:0];
    eth0.txPostCursor    = store[PHY_ETH0_2][4:0];
    eth0.pcsLoopbackEn   = store[DIAG_CTRL_1][0];
    eth0.macLoopbackEn   = store[DIAG_CTRL_1][1];
    eth0.macAddrSwapEn   = store[DIAG_CTRL_1][2];

    // Lower address is the lower byte
    nts.macAddress  = {store[LY2_MAC5], store[LY2_MAC4], store[LY2_MAC3],
                       store[LY2_MAC2], store[LY2_MAC1], store[LY2_MAC0]};
    nts.ipAddress   = {store[LY3_IP3], store[LY3_IP2], store[LY3_IP1], store[LY3_IP0]};
    nts.subNetMask  = {store[LY3_SNM3], store[LY3_SNM2], store[LY3_SNM1], store[LY3_SNM0]};
    nts.gatewayAddr = {store[LY3_GTW3], store[LY3_GTW2], store[LY3_GTW1], store[LY3_GTW0]};

    role.mc1MemTestCtrl = store[DIAG_CTRL_1][7:6];
    role.udpEchoCtrl    = store[DIAG_CTRL_2][1:0];
    role.udpPostDgmEn   = store[DIAG_CTRL_2][2];
    role.udpCaptDgmEn   = store[DIAG_CTRL_2][3];
    role.tcpEchoCtrl    = store[DIAG_CTRL_2][5:4];
    role.tcpPostSegEn   = store[DIAG_CTRL_2][6];
    role.tcpCaptSegEn   = store[DIAG_CTRL_2][7];
    role.roleWrReg      = {store[APP_WRROL1], store[APP_WRROL0]};
    role.fmcWrReg       = {store[APP_WRFMC3], store[APP_WRFMC2],
                           store[APP_WRFMC1], store[APP_WRFMC0]};
  end

endmodule

//--- hdl/emifSlave.sv
/*
 * EMIF bus slave. Samples the level strobes into one registered request
 * per shlClk cycle and registers the selected read byte back to the bus.
 */
`timescale 1ns/1ps
`include "mmio_params.svh"

module emifSlave
  import emifBusPkg::*;
(
  input  logic                        shlClk,
  input  logic                        reset,
  input  logic                        emifCsN,      // Chip select, low active
  input  logic                        emifWeN,      // Write enable, low active
  input  logic [`MMIO_BUS_ADDR_W-1:0] emifAddr,
  input  logic [`MMIO_DATA_W-1:0]     emifDataIn,
  input  logic [`MMIO_DATA_W-1:0]     rdByte,       // From readback mux
  output emifReq                      req,
  output logic [`MMIO_DATA_W-1:0]     emifDataOut
);

  emifReq reqNext;
  logic   lowerSel;    // Selected and in the register half
  logic   upperRdNext;
  logic   upperRd;     // Registered read of the upper half

  // -----------------------------------------------------------------------
  // Strobe decode
  // -----------------------------------------------------------------------
  assign lowerSel    = !emifCsN && !emifAddr[`MMIO_BUS_ADDR_W-1];
  assign upperRdNext = !emifCsN && emifAddr[`MMIO_BUS_ADDR_W-1] && emifWeN;

  always_comb
  begin
    reqNext.op   = opIdle;
    reqNext.addr = emifAddr[`MMIO_ADDR_W-1:0];
    reqNext.data = emifDataIn;
    if (lowerSel)
      reqNext.op = emifWeN ? opRead : opWrite;
  end

  // Request register, only the op is control state
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      req.op  <= opIdle;
      upperRd <= 1'b0;
    end
    else
    begin
      req.op  <= reqNext.op;
      upperRd <= upperRdNext;
    end
  end

  always_ff @(posedge shlClk)
  begin
    req.addr <= reqNext.addr;
    req.data <= reqNext.data;
  end

  // -----------------------------------------------------------------------
  // Read data register, holds until the next read
  // -----------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
      emifDataOut <= '0;
    else if (req.op == opRead)
      emifDataOut <= rdByte;
    else if (upperRd)
      emifDataOut <= '0;   // Upper half has no storage
  end

endmodule

//--- hdl/mmioRegPkg.sv
/*
 * Register addresses of the MMIO map and the shell-facing field groups:
 * live status going in, ETH0, network and role controls going out.
 */
`include "mmio_params.svh"

package mmioRegPkg;

  // -----------------------------------------------------------------------
  // Register addresses
  // -----------------------------------------------------------------------
  typedef enum logic [`MMIO_ADDR_W-1:0]
  {
    CFG_EMIF_ID    = `MMIO_CFG_BASE,           // RO constants
    CFG_EMIF_VER   = `MMIO_CFG_BASE + 7'd1,
    CFG_EMIF_REV   = `MMIO_CFG_BASE + 7'd2,
    CFG_TOP_ID     = `MMIO_CFG_BASE + 7'd4,
    CFG_TOP_YEAR   = `MMIO_CFG_BASE + 7'd5,    // RO, from timestamp
    CFG_TOP_MONTH  = `MMIO_CFG_BASE + 7'd6,
    CFG_TOP_DAY    = `MMIO_CFG_BASE + 7'd7,
    PHY_STAT       = `MMIO_PHY_BASE,           // RO live
    PHY_ETH0_0     = `MMIO_PHY_BASE + 7'd1,    // RW tuning
    PHY_ETH0_1     = `MMIO_PHY_BASE + 7'd2,
    PHY_ETH0_2     = `MMIO_PHY_BASE + 7'd3,
    LY2_CTRL       = `MMIO_LY2_BASE,
    LY2_STAT       = `MMIO_LY2_BASE + 7'd1,
    LY2_MAC0       = `MMIO_LY2_BASE + 7'd2,    // MAC bits 7..0
    LY2_MAC1       = `MMIO_LY2_BASE + 7'd3,
    LY2_MAC2       = `MMIO_LY2_BASE + 7'd4,
    LY2_MAC3       = `MMIO_LY2_BASE + 7'd5,
    LY2_MAC4       = `MMIO_LY2_BASE + 7'd6,
    LY2_MAC5       = `MMIO_LY2_BASE + 7'd7,
    LY3_CTRL0      = `MMIO_LY3_BASE,
    LY3_CTRL1      = `MMIO_LY3_BASE + 7'd1,
    LY3_STAT0      = `MMIO_LY3_BASE + 7'd2,
    LY3_STAT1      = `MMIO_LY3_BASE + 7'd3,
    LY3_IP0        = `MMIO_LY3_BASE + 7'd4,
    LY3_IP1        = `MMIO_LY3_BASE + 7'd5,
    LY3_IP2        = `MMIO_LY3_BASE + 7'd6,
    LY3_IP3        = `MMIO_LY3_BASE + 7'd7,
    LY3_SNM0       = `MMIO_LY3_BASE + 7'd8,
    LY3_SNM1       = `MMIO_LY3_BASE + 7'd9,
    LY3_SNM2       = `MMIO_LY3_BASE + 7'd10,
    LY3_SNM3       = `MMIO_LY3_BASE + 7'd11,
    LY3_GTW0       = `MMIO_LY3_BASE + 7'd12,
    LY3_GTW1       = `MMIO_LY3_BASE + 7'd13,
    LY3_GTW2       = `MMIO_LY3_BASE + 7'd14,
    LY3_GTW3       = `MMIO_LY3_BASE + 7'd15,
    APP_RDROL0     = `MMIO_APP_BASE,           // RO from role
    APP_RDROL1     = `MMIO_APP_BASE + 7'd1,
    APP_WRROL0     = `MMIO_APP_BASE + 7'd2,
    APP_WRROL1     = `MMIO_APP_BASE + 7'd3,
    APP_RDFMC0     = `MMIO_APP_BASE + 7'd4,    // RO from FMC
    APP_RDFMC1     = `MMIO_APP_BASE + 7'd5,
    APP_RDFMC2     = `MMIO_APP_BASE + 7'd6,
    APP_RDFMC3     = `MMIO_APP_BASE + 7'd7,
    APP_WRFMC0     = `MMIO_APP_BASE + 7'd8,
    APP_WRFMC1     = `MMIO_APP_BASE + 7'd9,
    APP_WRFMC2     = `MMIO_APP_BASE + 7'd10,
    APP_WRFMC3     = `MMIO_APP_BASE + 7'd11,
    DIAG_SCRATCH0  = `MMIO_DIAG_BASE,
    DIAG_SCRATCH1  = `MMIO_DIAG_BASE + 7'd1,
    DIAG_SCRATCH2  = `MMIO_DIAG_BASE + 7'd2,
    DIAG_SCRATCH3  = `MMIO_DIAG_BASE + 7'd3,
    DIAG_CTRL_1    = `MMIO_DIAG_BASE + 7'd4,   // Loopbacks, mem test
    DIAG_STAT_1    = `MMIO_DIAG_BASE + 7'd5,
    DIAG_CTRL_2    = `MMIO_DIAG_BASE + 7'd6    // UDP/TCP role test
  } regAddr;

  // -----------------------------------------------------------------------
  // Shell-facing field groups
  // -----------------------------------------------------------------------
  typedef struct packed
  {
    logic        mc0CalDone;
    logic        mc1CalDone;
    logic        ethCoreReady;
    logic        qpllLock;
    logic        camReady;
    logic [1:0]  memTestStat;  // MC1 memory test result
    logic [15:0] roleRdReg;
    logic [31:0] fmcRdReg;
    logic [31:0] timestamp;    // Day 31..27, month 26..23, year 22..17
  } shellStatus;

  typedef struct packed
  {
    logic       rxEqualizerMode;
    logic [3:0] txDriverSwing;
    logic [4:0] txPreCursor;
    logic [4:0] txPostCursor;
    logic       pcsLoopbackEn;
    logic       macLoopbackEn;
    logic       macAddrSwapEn;
  } eth0Ctrl;

  typedef struct packed
  {
    logic [47:0] macAddress;
    logic [31:0] ipAddress;
    logic [31:0] subNetMask;
    logic [31:0] gatewayAddr;
  } ntsCfg;

  typedef struct packed
  {
    logic [1:0]  mc1MemTestCtrl;
    logic [1:0]  udpEchoCtrl;
    logic        udpPostDgmEn;
    logic        udpCaptDgmEn;
    logic [1:0]  tcpEchoCtrl;
    logic        tcpPostSegEn;
    logic        tcpCaptSegEn;
    logic [15:0] roleWrReg;
    logic [31:0] fmcWrReg;
  } roleCtrl;

endpackage

//--- hdl/emifBusPkg.sv
/*
 * EMIF bus cycle as the client sees it after decoding the raw strobes.
 * Imported by the bus slave and by everything that consumes its request.
 */
`include "mmio_params.svh"

package emifBusPkg;

  // -----------------------------------------------------------------------
  // Kind of bus cycle
  // -----------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    opIdle  = 2'd0,  // No access, or upper-half access
    opRead  = 2'd1,
    opWrite = 2'd2
  } emifOp;

  // One decoded request, registered once per shlClk cycle
  typedef struct packed
  {
    emifOp                   op;
    logic [`MMIO_ADDR_W-1:0] addr;  // Lower-half register address
    logic [`MMIO_DATA_W-1:0] data;  // Write data, don't care on reads
  } emifReq;

endpackage

//--- hdl/mmio_params.svh
/*
 * Register map constants of the MMIO client: widths, bank base addresses,
 * ID bytes and reset defaults. Include wherever the map is needed.
 */
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// -------------------------------------------------------------------------
// Bus and register widths
// -------------------------------------------------------------------------
`define MMIO_BUS_ADDR_W 8     // Raw EMIF address, bit 7 selects upper half
`define MMIO_ADDR_W     7     // Register address inside lower half
`define MMIO_DATA_W     8
`define MMIO_REG_COUNT  128   // Bytes in the lower half

// Bank base addresses
`define MMIO_CFG_BASE  7'h00  // IDs and build timestamp
`define MMIO_PHY_BASE  7'h10  // PHY status, ETH0 tuning
`define MMIO_LY2_BASE  7'h20  // MAC layer
`define MMIO_LY3_BASE  7'h30  // IP layer
`define MMIO_APP_BASE  7'h40  // Role and FMC mailboxes
`define MMIO_DIAG_BASE 7'h70  // Scratch and loopback control

// Burned-in identification
`define MMIO_EMIF_ID  8'h3C
`define MMIO_EMIF_VER 8'h01
`define MMIO_EMIF_REV 8'h00
`define MMIO_TOP_ID   8'h81

// -------------------------------------------------------------------------
// Reset defaults, byte 0 at the lowest address
// -------------------------------------------------------------------------
`define MMIO_DEF_PHY_ETH0_0 8'h41  // Rx equalizer on, swing 4
`define MMIO_DEF_PHY_ETH0_1 8'h05  // Tx pre-cursor
`define MMIO_DEF_PHY_ETH0_2 8'h05  // Tx post-cursor
`define MMIO_DEF_IP0   8'h0A       // IP 10.12.200.19
`define MMIO_DEF_IP1   8'h0C
`define MMIO_DEF_IP2   8'hC8
`define MMIO_DEF_IP3   8'h13
`define MMIO_DEF_SNM0  8'hFF       // Mask 255.255.0.0
`define MMIO_DEF_SNM1  8'hFF
`define MMIO_DEF_SNM2  8'h00
`define MMIO_DEF_SNM3  8'h00
`define MMIO_DEF_GTW0  8'h0A       // Gateway 10.12.0.1
`define MMIO_DEF_GTW1  8'h0C
`define MMIO_DEF_GTW2  8'h00
`define MMIO_DEF_GTW3  8'h01
`define MMIO_DEF_SCR0  8'hDE       // Scratch pattern
`define MMIO_DEF_SCR1  8'hAD
`define MMIO_DEF_SCR2  8'hBE
`define MMIO_DEF_SCR3  8'hEF

`endif
